/* hw/simd_dec_pkg.sv */
package simd_dec_pkg;

	localparam int ns_id_bits = 3;
	localparam int ns_index_bits = 5;
	localparam int operand_bits = 3 * (ns_id_bits + ns_index_bits); // 24
	localparam int opcode_bits = 4;
	localparam int fn_bits = 4;
	localparam int inst_width = opcode_bits + fn_bits + operand_bits; // 32
	localparam int imem_addr_width = 10;
	localparam int group_id_bits = 4;
	localparam int num_groups = 1 << group_id_bits;
	localparam int iter_bits = operand_bits;

	typedef enum logic [opcode_bits-1:0] {
		op_ld_st = 4'd5,
		op_loop = 4'd7,
		op_permute = 4'd8,
		op_inst_group = 4'd10
	} opcode_e;

	// Function codes
	localparam logic [fn_bits-1:0] fn_ld_start = 4'd5;
	localparam logic [fn_bits-1:0] fn_st_start = 4'd13;
	localparam logic [fn_bits-1:0] fn_permute_start = 4'd3;
	localparam logic [fn_bits-1:0] fn_loop_iter = 4'd1; // Low half holds iteration count
	localparam logic [fn_bits-1:0] fn_loop_start = 4'd2; // Operands hold body length
	localparam logic [2:0] fn_group_buf_end = 3'b111; // Compared against fn[3:1]
	localparam logic [2:0] fn_group_ex_end = 3'b110;

	typedef enum logic [2:0] {
		idle,
		get_group_addr,
		inst_wait,
		in_loop,
		ld_wait,
		st_wait,
		permute_wait
	} seq_state_e;

	typedef enum logic [2:0] {
		kind_other,
		kind_loop_iter,
		kind_loop_start,
		kind_ld,
		kind_st,
		kind_permute,
		kind_group_start,
		kind_group_end // Buffer end and execution end, split by fn[1]
	} inst_kind_e;

endpackage

/* hw/inst_field_decode.sv */
`timescale 1ns/1ps

module inst_field_decode import simd_dec_pkg::*; (
	input  logic [inst_width-1:0]    instruction_in,
	output opcode_e                  opcode,
	output logic [fn_bits-1:0]       fn,
	output logic [ns_id_bits-1:0]    dest_ns_id,
	output logic [ns_id_bits-1:0]    src1_ns_id,
	output logic [ns_id_bits-1:0]    src2_ns_id,
	output logic [ns_index_bits-1:0] dest_ns_index_id,
	output logic [ns_index_bits-1:0] src1_ns_index_id,
	output logic [ns_index_bits-1:0] src2_ns_index_id,
	output logic [operand_bits-1:0]  operands,
	output inst_kind_e               inst_kind
);

	// Word layout from the top: opcode, fn, dest, src1, src2
	assign opcode = opcode_e'(instruction_in[inst_width-1 -: opcode_bits]);
	assign fn = instruction_in[operand_bits +: fn_bits];
	assign operands = instruction_in[operand_bits-1:0];

	assign dest_ns_id = instruction_in[23:21];
	assign dest_ns_index_id = instruction_in[20:16];
	assign src1_ns_id = instruction_in[15:13];
	assign src1_ns_index_id = instruction_in[12:8];
	assign src2_ns_id = instruction_in[7:5];
	assign src2_ns_index_id = instruction_in[4:0];

	always_comb begin
		inst_kind = kind_other;
		case (opcode)
		op_loop: begin
			if (fn == fn_loop_iter)
				inst_kind = kind_loop_iter;
			else if (fn == fn_loop_start)
				inst_kind = kind_loop_start;
		end
		op_ld_st: begin
			if (fn == fn_ld_start)
				inst_kind = kind_ld;
			else if (fn == fn_st_start)
				inst_kind = kind_st;
		end
		op_permute: begin
			if (fn == fn_permute_start)
				inst_kind = kind_permute;
		end
		op_inst_group: begin
			if (fn[3:2] == 2'b10) // SIMD group start
				inst_kind = kind_group_start;
			else if (fn[3:1] == fn_group_buf_end || fn[3:1] == fn_group_ex_end)
				inst_kind = kind_group_end;
		end
		default: inst_kind = kind_other;
		endcase
	end

endmodule

/* hw/loop_ctrl.sv */
`timescale 1ns/1ps

module loop_ctrl import simd_dec_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       accept,
	input  inst_kind_e                 inst_kind,
	input  logic [operand_bits-1:0]    operands,
	input  logic [imem_addr_width-1:0] fetch_addr,
	input  logic                       wrap,
	output logic [imem_addr_width-1:0] loop_start_addr,
	output logic                       loop_last_addr,
	output logic                       loop_done
);

	logic [iter_bits-1:0] iter_value;
	logic [iter_bits-1:0] iter_count;
	logic [imem_addr_width-1:0] start_addr_q;
	logic [imem_addr_width-1:0] end_addr_q;

	// Iteration target and running count
	always_ff @(posedge clk) begin
		if (reset) begin
			iter_value <= '0;
			iter_count <= iter_bits'(1);
		end else begin
			if (accept && inst_kind == kind_loop_iter)
				iter_value <= iter_bits'(operands[operand_bits/2-1:0]);
			if (accept && inst_kind == kind_loop_start)
				iter_count <= iter_bits'(1); // First pass of the body
			else if (wrap)
				iter_count <= iter_count + iter_bits'(1);
		end
	end

	// Body spans start+1 .. start+length
	always_ff @(posedge clk) begin
		if (accept && inst_kind == kind_loop_start) begin
			start_addr_q <= fetch_addr + imem_addr_width'(1);
			end_addr_q <= fetch_addr + operands[imem_addr_width-1:0];
		end
	end

	assign loop_start_addr = start_addr_q;
	assign loop_last_addr = (fetch_addr == end_addr_q);
	assign loop_done = (iter_count == iter_value);

	// Sequencer must leave the loop instead of wrapping past the target
	a_no_wrap_past_end: assert property (
		@(posedge clk) disable iff (reset)
		wrap |-> (iter_count != iter_value)
	) else $error("loop wrap after final iteration");

endmodule

/* hw/fetch_fsm.sv */
`timescale 1ns/1ps

module fetch_fsm import simd_dec_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  logic [imem_addr_width-1:0] group_buf_rd_data,
	input  logic                       group_buf_rd_v,
	input  logic                       instruction_in_v,
	input  inst_kind_e                 inst_kind,
	input  logic [fn_bits-1:0]         fn,
	input  logic                       simd_tiles_done,
	input  logic                       ld_mem_simd_done,
	input  logic                       st_mem_simd_done,
	input  logic                       data_shuffle_done,
	input  logic [imem_addr_width-1:0] loop_start_addr,
	input  logic                       loop_last_addr,
	input  logic                       loop_done,
	output logic                       accept,
	output logic                       wrap,
	output logic [imem_addr_width-1:0] fetch_addr,
	output logic [imem_addr_width-1:0] imem_rd_address,
	output logic                       imem_rd_req,
	output logic                       stall,
	output logic                       ready,
	output logic                       in_ld_st,
	output logic                       in_shuffle,
	output logic                       in_single_loop
);

	seq_state_e state_q, state_d;
	logic [imem_addr_width-1:0] addr_q, addr_d;
	logic req_q, req_d;
	logic stall_q, stall_d;
	logic ex_end;
	logic wait_done;

	assign accept = instruction_in_v && (state_q == inst_wait || state_q == in_loop);
	assign wrap = accept && state_q == in_loop && loop_last_addr && !loop_done;
	assign ex_end = inst_kind == kind_group_end && fn[3:1] == fn_group_ex_end
		&& simd_tiles_done;

	always_comb begin
		case (state_q)
		ld_wait: wait_done = ld_mem_simd_done;
		st_wait: wait_done = st_mem_simd_done;
		permute_wait: wait_done = data_shuffle_done;
		default: wait_done = 1'b0;
		endcase
	end

	always_comb begin
		state_d = state_q;
		addr_d = addr_q;
		req_d = 1'b0;
		stall_d = stall_q;
		case (state_q)
		idle: begin
			if (start)
				state_d = get_group_addr;
		end
		get_group_addr: begin
			if (group_buf_rd_v) begin
				state_d = inst_wait;
				addr_d = group_buf_rd_data;
				req_d = 1'b1;
			end
		end
		inst_wait: begin
			if (accept) begin
				if (ex_end) begin
					state_d = idle;
				end else if (inst_kind == kind_ld || inst_kind == kind_st
						|| inst_kind == kind_permute) begin
					state_d = (inst_kind == kind_ld) ? ld_wait :
						(inst_kind == kind_st) ? st_wait : permute_wait;
					stall_d = 1'b1; // Hold the address until the done strobe
				end else begin
					if (inst_kind == kind_loop_start)
						state_d = in_loop;
					addr_d = addr_q + imem_addr_width'(1);
					req_d = 1'b1;
				end
			end
		end
		in_loop: begin
			if (accept) begin
				req_d = 1'b1;
				if (wrap)
					addr_d = loop_start_addr;
				else
					addr_d = addr_q + imem_addr_width'(1);
				if (loop_last_addr && loop_done)
					state_d = inst_wait;
			end
		end
		ld_wait, st_wait, permute_wait: begin
			if (wait_done) begin
				state_d = inst_wait;
				addr_d = addr_q + imem_addr_width'(1);
				req_d = 1'b1;
				stall_d = 1'b0;
			end
		end
		default: state_d = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= idle;
			addr_q <= '0;
			req_q <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			state_q <= state_d;
			addr_q <= addr_d;
			req_q <= req_d;
			stall_q <= stall_d;
		end
	end

	assign fetch_addr = addr_q;
	assign imem_rd_address = addr_q;
	assign imem_rd_req = req_q;
	assign stall = stall_q;
	assign ready = (state_q == idle);
	assign in_ld_st = (state_q == ld_wait) || (state_q == st_wait);
	assign in_shuffle = (state_q == permute_wait);
	assign in_single_loop = (state_q == in_loop);

	a_no_req_when_parked: assert property (
		@(posedge clk) disable iff (reset)
		(state_q inside {idle, ld_wait, st_wait, permute_wait}) |-> !imem_rd_req
	) else $error("imem request while sequencer is parked");

	a_stall_not_ready: assert property (
		@(posedge clk) disable iff (reset)
		!(stall && ready)
	) else $error("stall and ready high together");

endmodule

/* hw/group_tracker.sv */
`timescale 1ns/1ps

module group_tracker import simd_dec_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     accept,
	input  inst_kind_e               inst_kind,
	input  logic [fn_bits-1:0]       fn,
	input  logic [ns_id_bits-1:0]    dest_ns_id,
	input  logic [ns_id_bits-1:0]    src1_ns_id,
	input  logic                     simd_tiles_done,
	output logic [group_id_bits-1:0] ld_st_group_id,
	output logic [num_groups-1:0]    st_config_done,
	output logic [group_id_bits-1:0] group_id,
	output logic                     buf_done,
	output logic                     done
);

	logic [group_id_bits-1:0] cur_group;
	logic buf_end;
	logic ex_end;

	assign buf_end = accept && inst_kind == kind_group_end && fn[3:1] == fn_group_buf_end;
	assign ex_end = accept && inst_kind == kind_group_end && fn[3:1] == fn_group_ex_end
		&& simd_tiles_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_group <= '0;
			st_config_done <= '0;
			buf_done <= 1'b0;
			done <= 1'b0;
		end else begin
			if (accept && inst_kind == kind_group_start)
				cur_group <= {fn[1:0], dest_ns_id[2:1]};
			if (accept && inst_kind == kind_st)
				st_config_done[cur_group] <= 1'b1; // Sticky until reset
			buf_done <= buf_end;
			done <= ex_end;
		end
	end

	always_ff @(posedge clk) begin
		if (buf_end)
			group_id <= group_id_bits'(src1_ns_id);
	end

	assign ld_st_group_id = cur_group;

endmodule

/* hw/simd_decoder_top.sv */
`timescale 1ns/1ps

module simd_decoder_top import simd_dec_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  logic [group_id_bits-1:0]   group_id_s,
	input  logic [inst_width-1:0]      instruction_in,
	input  logic                       instruction_in_v,
	input  logic [imem_addr_width-1:0] group_buf_rd_data,
	input  logic                       group_buf_rd_v,
	output logic                       group_buf_rd_req,
	output logic [group_id_bits-1:0]   group_buf_rd_addr,
	input  logic                       ld_mem_simd_done,
	input  logic                       st_mem_simd_done,
	input  logic                       simd_tiles_done,
	input  logic                       data_shuffle_done,
	output logic                       in_ld_st,
	output logic                       in_shuffle,
	output logic                       ready,
	output logic [num_groups-1:0]      st_config_done,
	output logic [group_id_bits-1:0]   ld_st_group_id,
	output logic                       stall,
	output logic [imem_addr_width-1:0] imem_rd_address,
	output logic                       imem_rd_req,
	output opcode_e                    opcode,
	output logic [fn_bits-1:0]         fn,
	output logic [ns_id_bits-1:0]      dest_ns_id,
	output logic [ns_index_bits-1:0]   dest_ns_index_id,
	output logic [ns_id_bits-1:0]      src1_ns_id,
	output logic [ns_index_bits-1:0]   src1_ns_index_id,
	output logic [ns_id_bits-1:0]      src2_ns_id,
	output logic [ns_index_bits-1:0]   src2_ns_index_id,
	output logic                       in_single_loop,
	output logic                       buf_done,
	output logic                       done,
	output logic [group_id_bits-1:0]   group_id
);

	logic [operand_bits-1:0] operands;
	inst_kind_e inst_kind;
	logic accept;
	logic wrap;
	logic [imem_addr_width-1:0] fetch_addr;
	logic [imem_addr_width-1:0] loop_start_addr;
	logic loop_last_addr;
	logic loop_done;

	// Group table lookup, one cycle after start
	always_ff @(posedge clk) begin
		if (reset)
			group_buf_rd_req <= 1'b0;
		else
			group_buf_rd_req <= start;
	end

	always_ff @(posedge clk) begin
		group_buf_rd_addr <= group_id_s;
	end

	inst_field_decode u_decode (
		.instruction_in   (instruction_in),
		.opcode           (opcode),
		.fn               (fn),
		.dest_ns_id       (dest_ns_id),
		.src1_ns_id       (src1_ns_id),
		.src2_ns_id       (src2_ns_id),
		.dest_ns_index_id (dest_ns_index_id),
		.src1_ns_index_id (src1_ns_index_id),
		.src2_ns_index_id (src2_ns_index_id),
		.operands         (operands),
		.inst_kind        (inst_kind)
	);

	loop_ctrl u_loop (
		.clk             (clk),
		.reset           (reset),
		.accept          (accept),
		.inst_kind       (inst_kind),
		.operands        (operands),
		.fetch_addr      (fetch_addr),
		.wrap            (wrap),
		.loop_start_addr (loop_start_addr),
		.loop_last_addr  (loop_last_addr),
		.loop_done       (loop_done)
	);

	fetch_fsm u_fetch (
		.clk               (clk),
		.reset             (reset),
		.start             (start),
		.group_buf_rd_data (group_buf_rd_data),
		.group_buf_rd_v    (group_buf_rd_v),
		.instruction_in_v  (instruction_in_v),
		.inst_kind         (inst_kind),
		.fn                (fn),
		.simd_tiles_done   (simd_tiles_done),
		.ld_mem_simd_done  (ld_mem_simd_done),
		.st_mem_simd_done  (st_mem_simd_done),
		.data_shuffle_done (data_shuffle_done),
		.loop_start_addr   (loop_start_addr),
		.loop_last_addr    (loop_last_addr),
		.loop_done         (loop_done),
		.accept            (accept),
		.wrap              (wrap),
		.fetch_addr        (fetch_addr),
		.imem_rd_address   (imem_rd_address),
		.imem_rd_req       (imem_rd_req),
		.stall             (stall),
		.ready             (ready),
		.in_ld_st          (in_ld_st),
		.in_shuffle        (in_shuffle),
		.in_single_loop    (in_single_loop)
	);

	group_tracker u_group (
		.clk             (clk),
		.reset           (reset),
		.accept          (accept),
		.inst_kind       (inst_kind),
		.fn              (fn),
		.dest_ns_id      (dest_ns_id),
		.src1_ns_id      (src1_ns_id),
		.simd_tiles_done (simd_tiles_done),
		.ld_st_group_id  (ld_st_group_id),
		.st_config_done  (st_config_done),
		.group_id        (group_id),
		.buf_done        (buf_done),
		.done            (done)
	);

endmodule

/* dv/decoder_checker.sv */
`timescale 1ns/1ps

module decoder_checker import simd_dec_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  logic [group_id_bits-1:0]   group_id_s,
	input  logic [inst_width-1:0]      instruction_in,
	input  logic                       instruction_in_v,
	input  logic [imem_addr_width-1:0] group_buf_rd_data,
	input  logic                       group_buf_rd_v,
	input  logic                       group_buf_rd_req,
	input  logic [group_id_bits-1:0]   group_buf_rd_addr,
	input  logic                       ld_mem_simd_done,
	input  logic                       st_mem_simd_done,
	input  logic                       simd_tiles_done,
	input  logic                       data_shuffle_done,
	input  logic                       in_ld_st,
	input  logic                       in_shuffle,
	input  logic                       ready,
	input  logic [num_groups-1:0]      st_config_done,
	input  logic [group_id_bits-1:0]   ld_st_group_id,
	input  logic                       stall,
	input  logic [imem_addr_width-1:0] imem_rd_address,
	input  logic                       imem_rd_req,
	input  opcode_e                    opcode,
	input  logic [fn_bits-1:0]         fn,
	input  logic [ns_id_bits-1:0]      dest_ns_id,
	input  logic [ns_index_bits-1:0]   dest_ns_index_id,
	input  logic [ns_id_bits-1:0]      src1_ns_id,
	input  logic [ns_index_bits-1:0]   src1_ns_index_id,
	input  logic [ns_id_bits-1:0]      src2_ns_id,
	input  logic [ns_index_bits-1:0]   src2_ns_index_id,
	input  logic                       in_single_loop,
	input  logic                       buf_done,
	input  logic                       done,
	input  logic [group_id_bits-1:0]   group_id,
	input  logic [imem_addr_width-1:0] exp_addr [0:63],
	input  int                         exp_count,
	output int                         value_errors,
	output int                         other_errors
);

	int val_errs = 0;
	int misc_errs = 0;
	int req_count;
	logic prev_reset = 1'b0;
	logic outstanding, start_q, gbv_q, accept_q, wait_q, ex_end_q, loop_start_q, wait_done_q;
	logic exp_buf_done, exp_done;
	logic exp_ready, exp_in_ld_st, exp_in_shuffle;
	logic [group_id_bits-1:0] start_group, cur_group, exp_group_id;
	logic [imem_addr_width-1:0] table_addr;
	logic [num_groups-1:0] exp_flags;
	logic [3:0] w_op, w_fn;
	logic is_ld, is_st, is_permute, is_wait;
	logic is_group_start, is_buf_end, is_ex_end, is_loop_start;

	assign value_errors = val_errs;
	assign other_errors = misc_errs;

	// Classification straight from the word's bit fields
	assign w_op = instruction_in[31:28];
	assign w_fn = instruction_in[27:24];
	assign is_ld = w_op == op_ld_st && w_fn == fn_ld_start;
	assign is_st = w_op == op_ld_st && w_fn == fn_st_start;
	assign is_permute = w_op == op_permute && w_fn == fn_permute_start;
	assign is_wait = is_ld || is_st || is_permute;
	assign is_group_start = w_op == op_inst_group && w_fn[3:2] == 2'b10;
	assign is_buf_end = w_op == op_inst_group && w_fn[3:1] == 3'b111;
	assign is_ex_end = w_op == op_inst_group && w_fn[3:1] == 3'b110 && simd_tiles_done;
	assign is_loop_start = w_op == op_loop && w_fn == fn_loop_start;

	task automatic value_check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			val_errs++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic fail(input string what);
		misc_errs++;
		$display("Check failed at %0t: %s", $time, what);
	endtask

	task automatic check_reset_values();
		value_check("imem_rd_req", 32'd0, 32'(imem_rd_req));
		value_check("in_single_loop", 32'd0, 32'(in_single_loop));
	endtask

	always @(posedge clk) begin
		prev_reset <= reset;
		if (reset) begin
			req_count <= 0;
			outstanding <= 1'b0;
			{start_q, gbv_q, accept_q, wait_q, ex_end_q, loop_start_q, wait_done_q} <= '0;
			exp_buf_done <= 1'b0;
			exp_done <= 1'b0;
			exp_ready <= 1'b1;
			exp_in_ld_st <= 1'b0;
			exp_in_shuffle <= 1'b0;
			cur_group <= '0;
			exp_flags <= '0;
		end else begin
			if (prev_reset)
				check_reset_values();
			value_check("group_buf_rd_req", 32'(start_q), 32'(group_buf_rd_req));
			if (group_buf_rd_req)
				value_check("group_buf_rd_addr", 32'(start_group), 32'(group_buf_rd_addr));
			if (gbv_q) begin
				if (!imem_rd_req)
					fail("no fetch one cycle after the group table answer");
				value_check("first imem_rd_address", 32'(table_addr), 32'(imem_rd_address));
			end

			if (imem_rd_req) begin
				if (outstanding)
					fail("new fetch request before the previous word returned");
				if (req_count >= exp_count)
					fail("more fetch requests than expected");
				else
					value_check($sformatf("imem_rd_address[%0d]", req_count),
						32'(exp_addr[req_count]), 32'(imem_rd_address));
				req_count <= req_count + 1;
			end
			if (instruction_in_v && !outstanding)
				fail("instruction word returned without a request");
			if (imem_rd_req)
				outstanding <= 1'b1;
			else if (instruction_in_v)
				outstanding <= 1'b0;

			if (instruction_in_v) begin
				value_check("opcode", 32'(instruction_in[31:28]), 32'(opcode));
				value_check("fn", 32'(instruction_in[27:24]), 32'(fn));
				value_check("dest_ns_id", 32'(instruction_in[23:21]), 32'(dest_ns_id));
				value_check("dest_ns_index_id", 32'(instruction_in[20:16]),
					32'(dest_ns_index_id));
				value_check("src1_ns_id", 32'(instruction_in[15:13]), 32'(src1_ns_id));
				value_check("src1_ns_index_id", 32'(instruction_in[12:8]),
					32'(src1_ns_index_id));
				value_check("src2_ns_id", 32'(instruction_in[7:5]), 32'(src2_ns_id));
				value_check("src2_ns_index_id", 32'(instruction_in[4:0]),
					32'(src2_ns_index_id));
			end

			// What must follow an accepted word
			if (accept_q) begin
				if (ex_end_q) begin
					if (imem_rd_req)
						fail("fetch request after the execution end");
				end else if (!wait_q && !imem_rd_req) begin
					fail("no fetch one cycle after an accepted word");
				end
				if (loop_start_q)
					value_check("in_single_loop", 32'd1, 32'(in_single_loop));
			end

			value_check("ready", 32'(exp_ready), 32'(ready));
			value_check("in_ld_st", 32'(exp_in_ld_st), 32'(in_ld_st));
			value_check("in_shuffle", 32'(exp_in_shuffle), 32'(in_shuffle));
			value_check("stall", 32'(exp_in_ld_st || exp_in_shuffle), 32'(stall));
			if ((exp_in_ld_st || exp_in_shuffle) && imem_rd_req)
				fail("fetch request during a load, store or permute wait");
			if (wait_done_q && !imem_rd_req)
				fail("no fetch one cycle after the wait ended");

			value_check("st_config_done", 32'(exp_flags), 32'(st_config_done));
			value_check("ld_st_group_id", 32'(cur_group), 32'(ld_st_group_id));
			value_check("buf_done", 32'(exp_buf_done), 32'(buf_done));
			value_check("done", 32'(exp_done), 32'(done));
			if (buf_done)
				value_check("group_id", 32'(exp_group_id), 32'(group_id));
			if (done && req_count != exp_count)
				fail("fetch count at done differs from the expected list");

			start_q <= start;
			gbv_q <= group_buf_rd_v;
			accept_q <= instruction_in_v;
			wait_q <= is_wait;
			ex_end_q <= is_ex_end;
			loop_start_q <= is_loop_start;
			wait_done_q <= (exp_in_ld_st || exp_in_shuffle)
				&& (ld_mem_simd_done || st_mem_simd_done || data_shuffle_done);
			exp_buf_done <= instruction_in_v && is_buf_end;
			exp_done <= instruction_in_v && is_ex_end;
			if (start)
				exp_ready <= 1'b0;
			else if (instruction_in_v && is_ex_end)
				exp_ready <= 1'b1;
			// Wait level from the start word to its done strobe
			if (instruction_in_v && (is_ld || is_st))
				exp_in_ld_st <= 1'b1;
			else if (ld_mem_simd_done || st_mem_simd_done)
				exp_in_ld_st <= 1'b0;
			if (instruction_in_v && is_permute)
				exp_in_shuffle <= 1'b1;
			else if (data_shuffle_done)
				exp_in_shuffle <= 1'b0;
			if (instruction_in_v && is_group_start)
				cur_group <= {w_fn[1:0], instruction_in[23:22]};
			if (instruction_in_v && is_st)
				exp_flags[cur_group] <= 1'b1;
		end
		if (start)
			start_group <= group_id_s;
		if (group_buf_rd_v)
			table_addr <= group_buf_rd_data;
		if (instruction_in_v && is_buf_end)
			exp_group_id <= {1'b0, instruction_in[15:13]}; // From src1 namespace id
	end

endmodule

/* dv/tb_simd_decoder.sv */
`timescale 1ns/1ps

module tb_simd_decoder import simd_dec_pkg::*; ();

	localparam int stim_words = 1280; // Program 000-3ff, table 400-40f, header 410, list 420+

	logic clk;
	logic reset;
	logic start;
	logic [group_id_bits-1:0] group_id_s;
	logic [inst_width-1:0] instruction_in = '0;
	logic instruction_in_v = 1'b0;
	logic [imem_addr_width-1:0] group_buf_rd_data = '0;
	logic group_buf_rd_v = 1'b0;
	logic group_buf_rd_req;
	logic [group_id_bits-1:0] group_buf_rd_addr;
	logic ld_mem_simd_done = 1'b0;
	logic st_mem_simd_done = 1'b0;
	logic simd_tiles_done = 1'b0;
	logic data_shuffle_done = 1'b0;
	logic in_ld_st, in_shuffle, ready, stall, imem_rd_req, in_single_loop, buf_done, done;
	logic [num_groups-1:0] st_config_done;
	logic [group_id_bits-1:0] ld_st_group_id;
	logic [group_id_bits-1:0] group_id;
	logic [imem_addr_width-1:0] imem_rd_address;
	opcode_e opcode;
	logic [fn_bits-1:0] fn;
	logic [ns_id_bits-1:0] dest_ns_id, src1_ns_id, src2_ns_id;
	logic [ns_index_bits-1:0] dest_ns_index_id, src1_ns_index_id, src2_ns_index_id;

	logic [inst_width-1:0] stim [0:stim_words-1];
	logic [imem_addr_width-1:0] exp_addr [0:63];
	int exp_count;
	int value_errors;
	int other_errors;
	integer seed = 66383;
	int wait_cnt = 0;
	logic wait_armed = 1'b0;
	logic req_q = 1'b0;
	logic gb_req_q = 1'b0;
	logic [imem_addr_width-1:0] req_addr_q;

	simd_decoder_top DUT (.*);

	decoder_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Instruction memory, one word two cycles after each request
	always @(posedge clk) begin
		req_q <= imem_rd_req;
		req_addr_q <= imem_rd_address;
		instruction_in_v <= req_q;
		if (req_q)
			instruction_in <= stim[{1'b0, req_addr_q}];
	end

	always @(posedge clk) begin
		gb_req_q <= group_buf_rd_req;
		group_buf_rd_v <= gb_req_q;
		if (gb_req_q)
			group_buf_rd_data <= stim[{7'h40, group_buf_rd_addr}][imem_addr_width-1:0];
		if (buf_done)
			simd_tiles_done <= 1'b1; // Last tile finishes once the buffer ends
	end

	// Load, store and permute units answer after a random delay
	always @(posedge clk) begin
		ld_mem_simd_done <= 1'b0;
		st_mem_simd_done <= 1'b0;
		data_shuffle_done <= 1'b0;
		if (stall && !wait_armed) begin
			wait_armed <= 1'b1;
			wait_cnt <= 1 + int'({$random(seed)} % 4);
		end else if (wait_cnt > 1) begin
			wait_cnt <= wait_cnt - 1;
		end else if (wait_cnt == 1) begin
			wait_cnt <= 0;
			if (instruction_in[27:24] == fn_ld_start)
				ld_mem_simd_done <= 1'b1;
			else if (instruction_in[27:24] == fn_st_start)
				st_mem_simd_done <= 1'b1;
			else
				data_shuffle_done <= 1'b1;
		end else if (!stall) begin
			wait_armed <= 1'b0;
		end
	end

	initial begin
		for (int i = 0; i < stim_words; i++)
			stim[i] = {16'hf00d, 16'(i)};
		$readmemh("dv/decoder_input.txt", stim);
		exp_count = int'(stim[11'h411]);
		for (int i = 0; i < 64; i++)
			exp_addr[i] = stim[11'h420 + 11'(i)][imem_addr_width-1:0];
		reset = 1'b1;
		start = 1'b0;
		group_id_s = stim[11'h410][group_id_bits-1:0];
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (done !== 1'b1)
			@(posedge clk);
		repeat (4) @(posedge clk);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog sized from the expected fetch count
	initial begin
		wait (reset === 1'b0);
		repeat (40 * exp_count + 200) @(posedge clk);
		$display("Timeout: the sequencer never signalled done");
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* dv/decoder_input.txt */
// Hex words by section: @000-3ff program word at that imem address, @400-40f group start
// table, @410 start group id, @411 expected fetch count, @420 expected fetch addresses
@020
A9800000 // Group start, group 6
12123456
71000003 // Loop iteration value 3
72000002 // Loop start, body of 2
3A0B0C0D
4C112233
55010203 // LD start
5D040506 // ST start
83070809 // Permute start
AC000000 // Execution end before tiles are done
AE00A000 // Buffer end, src1 id 5
AC000000 // Execution end
@400
000 100 180 020 200 240 280 2C0
300 320 340 360 380 3A0 3C0 3E0
@410
3 10
@420
020 021 022 023 024 025 024 025
024 025 026 027 028 029 02A 02B

/* flist.f */
hw/simd_dec_pkg.sv
hw/inst_field_decode.sv
hw/loop_ctrl.sv
hw/fetch_fsm.sv
hw/group_tracker.sv
hw/simd_decoder_top.sv
dv/decoder_checker.sv
dv/tb_simd_decoder.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_simd_decoder -f flist.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| echo "Build or simulation error"
grep -qx "Testbench passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
